// File: source/img_pkg.sv
`default_nettype none

package img_pkg;

    // ==========================================================
    // Sizes and widths
    // ==========================================================
    localparam int WORD_WIDTH = 16;
    localparam int HEADER_WORDS = 4;
    localparam int HEADER_WIDTH = HEADER_WORDS * WORD_WIDTH;
    localparam int HDR_COUNT_WIDTH = $clog2(HEADER_WORDS);
    localparam int PIXEL_WIDTH = 12;

    // Top pixel bits tested for highlight and shadow
    localparam int STAT_BITS = 7;
    localparam int STAT_WIDTH = 18;

    localparam int BUFFER_WORDS = 1024;
    localparam int ADDR_WIDTH = 10;
    // One bit wider than the address so a full buffer can be counted
    localparam int COUNT_WIDTH = 11;

    // ==========================================================
    // State encodings
    // ==========================================================
    typedef enum logic [2:0] {
        CAP_IDLE,
        CAP_HEADER,
        CAP_WAIT_INVALID,
        CAP_WAIT_START,
        CAP_FRAME,
        CAP_SUM_LOW,
        CAP_SUM_HIGH
    } capture_state_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_CAPTURE,
        CTRL_READOUT
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/fletcher_checksum.sv
`timescale 1ns/1ns
`default_nettype none

module fletcher_checksum import img_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  enable,
    input  logic [WORD_WIDTH-1:0] data,
    output logic [WORD_WIDTH-1:0] sum_a,
    output logic [WORD_WIDTH-1:0] sum_b
);

    logic [WORD_WIDTH-1:0] sum_a_next;
    logic [WORD_WIDTH-1:0] sum_b_next;

    // Addition modulo 65535; both operands stay below 2^16
    function automatic logic [WORD_WIDTH-1:0] add_mod(
        input logic [WORD_WIDTH-1:0] x,
        input logic [WORD_WIDTH-1:0] y
    );
        logic [WORD_WIDTH:0] s;
        s = x + y;
        if (s >= {1'b0, {WORD_WIDTH{1'b1}}}) begin
            s = s - {1'b0, {WORD_WIDTH{1'b1}}};
        end
        return s[WORD_WIDTH-1:0];
    endfunction

    always_comb begin
        sum_a_next = add_mod(sum_a, data);
        sum_b_next = add_mod(sum_b, sum_a_next);
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (enable) begin
            sum_a <= sum_a_next;
            sum_b <= sum_b_next;
        end
    end

endmodule

`default_nettype wire

// File: source/pixel_stats.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_stats import img_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clear,
    input  logic                   active,
    input  logic                   line_valid,
    input  logic                   frame_valid,
    input  logic [PIXEL_WIDTH-1:0] pixel,
    output logic [STAT_WIDTH-1:0]  highlight_count,
    output logic [STAT_WIDTH-1:0]  shadow_count
);

    logic [1:0]             col;
    logic [1:0]             row;
    logic                   lv_prev;
    logic                   sample;
    logic [PIXEL_WIDTH-1:0] pixel_q;
    logic [STAT_BITS-1:0]   top_bits;

    assign top_bits = pixel_q[PIXEL_WIDTH-1 -: STAT_BITS];

    always_ff @(posedge clk) begin
        pixel_q <= pixel;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            col <= '0;
            row <= '0;
            lv_prev <= 1'b0;
            sample <= 1'b0;
        end else begin
            lv_prev <= line_valid;
            // Column position within a line, modulo 4
            col <= line_valid ? col + 2'd1 : 2'd0;
            // Row steps when a line ends
            if (!frame_valid) begin
                row <= '0;
            end else if (lv_prev && !line_valid) begin
                row <= row + 2'd1;
            end
            sample <= active && line_valid && (col == 2'd0) && (row == 2'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            highlight_count <= '0;
            shadow_count <= '0;
        end else if (sample) begin
            if (&top_bits) highlight_count <= highlight_count + 1'b1;
            if (~|top_bits) shadow_count <= shadow_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/pixel_capture.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_capture import img_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    capture_start,
    input  logic [HEADER_WIDTH-1:0] header,
    input  logic [PIXEL_WIDTH-1:0]  img_d,
    input  logic                    img_fv,
    input  logic                    img_lv,
    output logic                    wr_en,
    output logic [WORD_WIDTH-1:0]   wr_data,
    output logic                    capture_finished,
    output logic [STAT_WIDTH-1:0]   highlight_count,
    output logic [STAT_WIDTH-1:0]   shadow_count
);

    capture_state_t             state;
    logic [PIXEL_WIDTH-1:0]     img_d_q;
    logic                       img_fv_q;
    logic                       img_lv_q;
    logic [HEADER_WIDTH-1:0]    header_shift;
    logic [HDR_COUNT_WIDTH-1:0] header_left;
    logic                       feed_checksum;
    logic [WORD_WIDTH-1:0]      sum_a;
    logic [WORD_WIDTH-1:0]      sum_b;
    logic [WORD_WIDTH-1:0]      sum_hold;

    function automatic logic [WORD_WIDTH-1:0] swap_bytes(input logic [WORD_WIDTH-1:0] w);
        return {w[7:0], w[15:8]};
    endfunction

    // Checksum sees every header and pixel word, little-endian
    fletcher_checksum u_checksum (
        .clk    (clk),
        .reset  (reset),
        .clear  (capture_start),
        .enable (feed_checksum),
        .data   (swap_bytes(wr_data)),
        .sum_a  (sum_a),
        .sum_b  (sum_b)
    );

    pixel_stats u_stats (
        .clk             (clk),
        .reset           (reset),
        .clear           (capture_start),
        .active          (state == CAP_FRAME),
        .line_valid      (img_lv_q),
        .frame_valid     (img_fv_q),
        .pixel           (img_d_q),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    // ==========================================================
    // Word datapath
    // ==========================================================
    always_ff @(posedge clk) begin
        img_d_q <= img_d;
        if (capture_start) begin
            wr_data <= header[HEADER_WIDTH-1 -: WORD_WIDTH];
            header_shift <= header << WORD_WIDTH;
        end else begin
            case (state)
                CAP_HEADER: begin
                    wr_data <= header_shift[HEADER_WIDTH-1 -: WORD_WIDTH];
                    header_shift <= header_shift << WORD_WIDTH;
                end
                // Low byte first, then the top nibble
                CAP_FRAME: wr_data <= {img_d_q[7:0], 4'b0000, img_d_q[11:8]};
                CAP_SUM_LOW: begin
                    wr_data <= swap_bytes(sum_a);
                    sum_hold <= sum_b;
                end
                CAP_SUM_HIGH: wr_data <= swap_bytes(sum_hold);
                default: ;
            endcase
        end
    end

    // ==========================================================
    // Capture FSM
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= CAP_IDLE;
            img_fv_q <= 1'b0;
            img_lv_q <= 1'b0;
            header_left <= '0;
            wr_en <= 1'b0;
            feed_checksum <= 1'b0;
            capture_finished <= 1'b0;
        end else begin
            img_fv_q <= img_fv;
            img_lv_q <= img_lv;
            wr_en <= 1'b0;
            feed_checksum <= 1'b0;
            capture_finished <= 1'b0;
            case (state)
                CAP_HEADER: begin
                    wr_en <= 1'b1;
                    feed_checksum <= 1'b1;
                    header_left <= header_left - 1'b1;
                    if (header_left == HDR_COUNT_WIDTH'(1)) state <= CAP_WAIT_INVALID;
                end
                // Frame edges taken from the raw input, one cycle ahead of the pixels
                CAP_WAIT_INVALID: if (!img_fv) state <= CAP_WAIT_START;
                CAP_WAIT_START: if (img_fv) state <= CAP_FRAME;
                CAP_FRAME: begin
                    wr_en <= img_lv_q;
                    feed_checksum <= img_lv_q;
                    if (!img_fv_q) state <= CAP_SUM_LOW;
                end
                CAP_SUM_LOW: begin
                    wr_en <= 1'b1;
                    state <= CAP_SUM_HIGH;
                end
                CAP_SUM_HIGH: begin
                    wr_en <= 1'b1;
                    capture_finished <= 1'b1;
                    state <= CAP_IDLE;
                end
                default: ;
            endcase
            if (capture_start) begin
                state <= CAP_HEADER;
                header_left <= HDR_COUNT_WIDTH'(HEADER_WORDS - 1);
                wr_en <= 1'b1;
                feed_checksum <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/image_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module image_buffer import img_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   capture_start,
    input  logic                   wr_en,
    input  logic [WORD_WIDTH-1:0]  wr_data,
    input  logic                   readout_begin,
    output logic                   readout_ready,
    input  logic                   readout_trigger,
    output logic [WORD_WIDTH-1:0]  readout_data,
    output logic                   readout_finished,
    output logic [COUNT_WIDTH-1:0] word_count
);

    logic [WORD_WIDTH-1:0]  mem [BUFFER_WORDS];
    logic [COUNT_WIDTH-1:0] rd_ptr;
    logic                   wr_ok;
    logic                   consume;
    logic                   more;
    logic                   rd_en;
    logic [ADDR_WIDTH-1:0]  rd_addr;

    // Word count doubles as the write pointer and saturates when full
    assign wr_ok = wr_en && (word_count < COUNT_WIDTH'(BUFFER_WORDS));
    assign consume = readout_ready && readout_trigger;
    assign more = rd_ptr < word_count;
    assign rd_en = readout_begin || (consume && more);
    assign rd_addr = readout_begin ? '0 : rd_ptr[ADDR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (wr_ok) mem[word_count[ADDR_WIDTH-1:0]] <= wr_data;
        if (rd_en) readout_data <= mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            word_count <= '0;
            rd_ptr <= '0;
            readout_ready <= 1'b0;
            readout_finished <= 1'b0;
        end else begin
            readout_finished <= 1'b0;
            if (capture_start) begin
                word_count <= '0;
            end else if (wr_ok) begin
                word_count <= word_count + 1'b1;
            end
            if (readout_begin) begin
                // Word 0 is fetched now, so the next read is word 1
                rd_ptr <= COUNT_WIDTH'(1);
                readout_ready <= (word_count != '0);
                readout_finished <= (word_count == '0);
            end else if (consume) begin
                if (more) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end else begin
                    readout_ready <= 1'b0;
                    readout_finished <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/capture_control.sv
`timescale 1ns/1ns
`default_nettype none

module capture_control import img_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic cmd_capture,
    input  logic cmd_readout,
    input  logic capture_finished,
    input  logic readout_finished,
    output logic capture_start,
    output logic readout_begin,
    output logic capture_done,
    output logic readout_done,
    output logic busy
);

    ctrl_state_t state;

    assign busy = (state != CTRL_IDLE);

    // ==========================================================
    // Command FSM
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= CTRL_IDLE;
            capture_start <= 1'b0;
            readout_begin <= 1'b0;
            capture_done <= 1'b0;
            readout_done <= 1'b0;
        end else begin
            capture_start <= 1'b0;
            readout_begin <= 1'b0;
            capture_done <= 1'b0;
            readout_done <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    // Capture has priority over readout
                    if (cmd_capture) begin
                        capture_start <= 1'b1;
                        state <= CTRL_CAPTURE;
                    end else if (cmd_readout) begin
                        readout_begin <= 1'b1;
                        state <= CTRL_READOUT;
                    end
                end
                CTRL_CAPTURE: begin
                    // Commands are dropped until the capture completes
                    if (capture_finished) begin
                        capture_done <= 1'b1;
                        state <= CTRL_IDLE;
                    end
                end
                CTRL_READOUT: begin
                    if (readout_finished) begin
                        readout_done <= 1'b1;
                        state <= CTRL_IDLE;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/img_controller.sv
`timescale 1ns/1ns
`default_nettype none

module img_controller import img_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_capture,
    input  logic                    cmd_readout,
    input  logic [HEADER_WIDTH-1:0] cmd_header,
    input  logic [PIXEL_WIDTH-1:0]  img_d,
    input  logic                    img_fv,
    input  logic                    img_lv,
    output logic                    readout_ready,
    input  logic                    readout_trigger,
    output logic [WORD_WIDTH-1:0]   readout_data,
    output logic                    capture_done,
    output logic                    readout_done,
    output logic                    busy,
    output logic [COUNT_WIDTH-1:0]  word_count,
    output logic [STAT_WIDTH-1:0]   highlight_count,
    output logic [STAT_WIDTH-1:0]   shadow_count
);

    logic                  capture_start;
    logic                  readout_begin;
    logic                  capture_finished;
    logic                  readout_finished;
    logic                  wr_en;
    logic [WORD_WIDTH-1:0] wr_data;

    capture_control u_control (
        .clk              (clk),
        .reset            (reset),
        .cmd_capture      (cmd_capture),
        .cmd_readout      (cmd_readout),
        .capture_finished (capture_finished),
        .readout_finished (readout_finished),
        .capture_start    (capture_start),
        .readout_begin    (readout_begin),
        .capture_done     (capture_done),
        .readout_done     (readout_done),
        .busy             (busy)
    );

    pixel_capture u_capture (
        .clk              (clk),
        .reset            (reset),
        .capture_start    (capture_start),
        .header           (cmd_header),
        .img_d            (img_d),
        .img_fv           (img_fv),
        .img_lv           (img_lv),
        .wr_en            (wr_en),
        .wr_data          (wr_data),
        .capture_finished (capture_finished),
        .highlight_count  (highlight_count),
        .shadow_count     (shadow_count)
    );

    image_buffer u_buffer (
        .clk              (clk),
        .reset            (reset),
        .capture_start    (capture_start),
        .wr_en            (wr_en),
        .wr_data          (wr_data),
        .readout_begin    (readout_begin),
        .readout_ready    (readout_ready),
        .readout_trigger  (readout_trigger),
        .readout_data     (readout_data),
        .readout_finished (readout_finished),
        .word_count       (word_count)
    );

endmodule

`default_nettype wire

// File: tb/img_sensor_model.sv
`timescale 1ns/1ns
`default_nettype none

module img_sensor_model import img_pkg::*; (
    input  logic                   clk,
    input  logic                   enable,
    input  int                     lines,
    input  int                     pixels,
    output logic [PIXEL_WIDTH-1:0] img_d,
    output logic                   img_fv,
    output logic                   img_lv,
    output logic                   frame_start
);

    localparam int DRIVE_DELAY = 5;
    localparam int FV_LEAD = 2;
    localparam int H_BLANK = 3;
    localparam int FV_TAIL = 1;
    localparam int V_BLANK = 6;

    // One sensor cycle, outputs change shortly after the rising edge
    task automatic step(
        input logic                   fv,
        input logic                   lv,
        input logic [PIXEL_WIDTH-1:0] d,
        input logic                   first
    );
        #DRIVE_DELAY;
        img_fv = fv;
        img_lv = lv;
        img_d = d;
        frame_start = first;
        @(posedge clk);
    endtask

    // Grid pixels cycle through full scale, zero and a random value
    function automatic logic [PIXEL_WIDTH-1:0] pick_pixel(input int x, input int y);
        if ((x % 4 == 0) && (y % 4 == 0)) begin
            case ((x / 4 + y / 4) % 3)
                0: return '1;
                1: return '0;
                default: ;
            endcase
        end
        return PIXEL_WIDTH'($urandom);
    endfunction

    initial begin
        int n_lines;
        int n_pixels;
        img_d = '0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        frame_start = 1'b0;
        forever begin
            @(posedge clk);
            if (enable) begin
                // Frame size is fixed once the frame has started
                n_lines = lines;
                n_pixels = pixels;
                for (int i = 0; i < FV_LEAD; i++) begin
                    step(1'b1, 1'b0, '0, i == 0);
                end
                for (int y = 0; y < n_lines; y++) begin
                    for (int x = 0; x < n_pixels; x++) begin
                        step(1'b1, 1'b1, pick_pixel(x, y), 1'b0);
                    end
                    repeat (H_BLANK) step(1'b1, 1'b0, '0, 1'b0);
                end
                repeat (FV_TAIL) step(1'b1, 1'b0, '0, 1'b0);
                repeat (V_BLANK) step(1'b0, 1'b0, '0, 1'b0);
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/img_controller_tb.sv
`timescale 1ns/1ns
`default_nettype none

module img_controller_tb import img_pkg::*; ();

    localparam int DRIVE_DELAY = 5;
    localparam int LINES_A = 8;
    localparam int PIXELS_A = 12;
    localparam int LINES_B = 10;
    localparam int PIXELS_B = 8;

    // Upper bound on one sensor frame including blanking
    function automatic int frame_cycles(input int n_lines, input int n_pixels);
        return n_lines * (n_pixels + 4) + 16;
    endfunction

    // Each capture may span two frames and readout takes under two cycles per word
    localparam int RUN_CYCLES = 2 * frame_cycles(LINES_A, PIXELS_A)
        + 2 * frame_cycles(LINES_B, PIXELS_B)
        + 2 * (HEADER_WORDS + LINES_A * PIXELS_A + 2)
        + 2 * (HEADER_WORDS + LINES_B * PIXELS_B + 2);
    localparam int TIMEOUT_CYCLES = 4 * RUN_CYCLES;

    logic                    clk;
    logic                    reset;
    logic                    cmd_capture;
    logic                    cmd_readout;
    logic [HEADER_WIDTH-1:0] cmd_header;
    logic [PIXEL_WIDTH-1:0]  img_d;
    logic                    img_fv;
    logic                    img_lv;
    logic                    readout_ready;
    logic                    readout_trigger;
    logic [WORD_WIDTH-1:0]   readout_data;
    logic                    capture_done;
    logic                    readout_done;
    logic                    busy;
    logic [COUNT_WIDTH-1:0]  word_count;
    logic [STAT_WIDTH-1:0]   highlight_count;
    logic [STAT_WIDTH-1:0]   shadow_count;
    logic                    frame_start;
    logic                    sensor_on;
    int                      lines;
    int                      pixels;

    // Monitor state
    int                     cycle_count = 0;
    logic                   readout_on;
    logic                   capturing;
    logic                   armed;
    logic                   recording;
    int                     capture_done_count;
    int                     readout_done_count;
    logic                   prev_ready;
    logic                   prev_trigger;
    logic [WORD_WIDTH-1:0]  prev_data;
    logic [PIXEL_WIDTH-1:0] frame_pixels[$];
    logic [WORD_WIDTH-1:0]  got_words[$];
    logic [WORD_WIDTH-1:0]  exp_words[$];
    int                     exp_highlight;
    int                     exp_shadow;

    img_controller DUT (
        .clk             (clk),
        .reset           (reset),
        .cmd_capture     (cmd_capture),
        .cmd_readout     (cmd_readout),
        .cmd_header      (cmd_header),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data),
        .capture_done    (capture_done),
        .readout_done    (readout_done),
        .busy            (busy),
        .word_count      (word_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    img_sensor_model u_sensor (
        .clk         (clk),
        .enable      (sensor_on),
        .lines       (lines),
        .pixels      (pixels),
        .img_d       (img_d),
        .img_fv      (img_fv),
        .img_lv      (img_lv),
        .frame_start (frame_start)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic explain_failure(input string msg);
        $display("%s", msg);
        stop_with_failure();
    endtask

    task automatic mismatch(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
        $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        stop_with_failure();
    endtask

    function automatic logic [WORD_WIDTH-1:0] byte_swap(input logic [WORD_WIDTH-1:0] w);
        return {w[7:0], w[15:8]};
    endfunction

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            explain_failure($sformatf("Timeout after %0d cycles, the run did not end", cycle_count));
        end
    end

    // Random back-pressure on the readout stream
    always @(posedge clk) begin
        #DRIVE_DELAY;
        readout_trigger = readout_on && ($urandom % 4 != 0);
    end

    // ==========================================================
    // Monitors sampled at the falling edge
    // ==========================================================
    always @(negedge clk) begin
        if (!reset) begin
            assert (!(capturing && readout_ready))
                else explain_failure("readout_ready rose while a capture was running");
            if (prev_ready && !prev_trigger) begin
                assert (readout_ready)
                    else explain_failure("readout_ready dropped while readout_trigger was low");
                assert (readout_data == prev_data)
                    else mismatch("held readout_data", prev_data, readout_data);
            end
            prev_ready = readout_ready;
            prev_trigger = readout_trigger;
            prev_data = readout_data;
            if (readout_ready && readout_trigger) got_words.push_back(readout_data);
            if (capture_done) begin
                capture_done_count++;
                capturing = 1'b0;
            end
            if (readout_done) begin
                readout_done_count++;
                assert (got_words.size() == exp_words.size())
                    else mismatch("words before readout_done", exp_words.size(), got_words.size());
            end
            // Record the first sensor frame that starts after a capture command
            if (frame_start && armed) begin
                armed = 1'b0;
                recording = 1'b1;
            end
            if (recording && !img_fv) recording = 1'b0;
            if (recording && img_lv) frame_pixels.push_back(img_d);
        end
    end

    task automatic send_command(input logic capture);
        @(posedge clk);
        #DRIVE_DELAY;
        if (capture) begin
            cmd_capture = 1'b1;
            capturing = 1'b1;
            armed = 1'b1;
            capture_done_count = 0;
            frame_pixels.delete();
        end else begin
            cmd_readout = 1'b1;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
    endtask

    task automatic build_expected(input logic [HEADER_WIDTH-1:0] header, input int n_pixels);
        int sum_a;
        int sum_b;
        logic [PIXEL_WIDTH-1:0] p;
        exp_words.delete();
        sum_a = 0;
        sum_b = 0;
        exp_highlight = 0;
        exp_shadow = 0;
        for (int i = 0; i < HEADER_WORDS; i++) begin
            exp_words.push_back(header[HEADER_WIDTH-1-i*WORD_WIDTH -: WORD_WIDTH]);
        end
        foreach (frame_pixels[i]) begin
            p = frame_pixels[i];
            exp_words.push_back({p[7:0], 4'b0000, p[11:8]});
            // Sparse grid of every fourth pixel in every fourth line
            if ((i % n_pixels) % 4 == 0 && (i / n_pixels) % 4 == 0) begin
                if (p[PIXEL_WIDTH-1 -: STAT_BITS] == '1) exp_highlight++;
                if (p[PIXEL_WIDTH-1 -: STAT_BITS] == '0) exp_shadow++;
            end
        end
        foreach (exp_words[i]) begin
            sum_a = (sum_a + byte_swap(exp_words[i])) % 65535;
            sum_b = (sum_b + sum_a) % 65535;
        end
        exp_words.push_back(byte_swap(WORD_WIDTH'(sum_a)));
        exp_words.push_back(byte_swap(WORD_WIDTH'(sum_b)));
    endtask

    task automatic capture_frame(input logic [HEADER_WIDTH-1:0] header, input int n_lines,
                                 input int n_pixels, input logic start_sensor);
        lines = n_lines;
        pixels = n_pixels;
        cmd_header = header;
        send_command(1'b1);
        repeat (2) @(negedge clk);
        assert (highlight_count == 0 && shadow_count == 0)
            else explain_failure("statistics not cleared at capture start");
        // Readout request while busy is dropped
        assert (busy) else explain_failure("busy low while a capture was running");
        send_command(1'b0);
        if (start_sensor) begin
            repeat (4) @(posedge clk);
            #DRIVE_DELAY;
            sensor_on = 1'b1;
        end
        while (capturing) @(negedge clk);
        repeat (4) @(negedge clk);
        assert (capture_done_count == 1)
            else mismatch("capture_done pulses", 1, capture_done_count);
        assert (!busy) else explain_failure("busy still high after capture_done");
        assert (frame_pixels.size() == n_lines * n_pixels)
            else mismatch("recorded pixels", n_lines * n_pixels, frame_pixels.size());
        build_expected(header, n_pixels);
        assert (word_count == HEADER_WORDS + n_lines * n_pixels + 2)
            else mismatch("word_count", HEADER_WORDS + n_lines * n_pixels + 2, word_count);
        assert (highlight_count == exp_highlight)
            else mismatch("highlight_count", exp_highlight, highlight_count);
        assert (shadow_count == exp_shadow)
            else mismatch("shadow_count", exp_shadow, shadow_count);
    endtask

    task automatic read_and_compare();
        string name;
        got_words.delete();
        readout_done_count = 0;
        readout_on = 1'b1;
        send_command(1'b0);
        while (readout_done_count == 0) @(negedge clk);
        readout_on = 1'b0;
        repeat (4) @(negedge clk);
        assert (readout_done_count == 1)
            else mismatch("readout_done pulses", 1, readout_done_count);
        assert (got_words.size() == exp_words.size())
            else mismatch("readout word total", exp_words.size(), got_words.size());
        foreach (exp_words[i]) begin
            if (i < HEADER_WORDS) begin
                name = $sformatf("header word %0d", i);
            end else if (i >= exp_words.size() - 2) begin
                name = $sformatf("checksum word %0d", i);
            end else begin
                name = $sformatf("pixel word %0d", i);
            end
            assert (got_words[i] == exp_words[i]) else mismatch(name, exp_words[i], got_words[i]);
        end
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        void'($urandom(46));
        reset = 1'b1;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        cmd_header = '0;
        readout_trigger = 1'b0;
        sensor_on = 1'b0;
        lines = LINES_A;
        pixels = PIXELS_A;
        readout_on = 1'b0;
        capturing = 1'b0;
        armed = 1'b0;
        recording = 1'b0;
        capture_done_count = 0;
        readout_done_count = 0;
        prev_ready = 1'b0;
        prev_trigger = 1'b0;
        prev_data = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk);
        assert (!busy && !readout_ready && !capture_done && !readout_done)
            else explain_failure("control outputs not low after reset");
        assert (word_count == 0) else mismatch("word_count after reset", 0, word_count);
        assert (highlight_count == 0 && shadow_count == 0)
            else explain_failure("statistics not zero after reset");

        // First frame starts after the command
        capture_frame(64'hA55A_0F1E_C3D2_7781, LINES_A, PIXELS_A, 1'b1);
        read_and_compare();

        // Second command lands in the middle of a sensor frame
        while (!frame_start) @(negedge clk);
        repeat (6) @(negedge clk);
        capture_frame(64'h1357_9BDF_2468_ACE0, LINES_B, PIXELS_B, 1'b0);
        read_and_compare();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: img_controller.f
source/img_pkg.sv
source/fletcher_checksum.sv
source/pixel_stats.sv
source/pixel_capture.sv
source/image_buffer.sv
source/capture_control.sv
source/img_controller.sv
tb/img_sensor_model.sv
tb/img_controller_tb.sv

// File: Bender.yml
package:
  name: img_controller

sources:
  - source/img_pkg.sv
  - source/fletcher_checksum.sv
  - source/pixel_stats.sv
  - source/pixel_capture.sv
  - source/image_buffer.sv
  - source/capture_control.sv
  - source/img_controller.sv
  - target: test
    files:
      - tb/img_sensor_model.sv
      - tb/img_controller_tb.sv
